// ==== rtl/cache_pkg.sv ====
// words and addresses are 32 bits, associativity is fixed at two and accesses are whole words only
`default_nettype none

package cache_pkg;

    // data and address words
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    localparam int WORD_BYTES = 4;  // no byte enables
    localparam int ASSOC = 2;  // the replacement table assumes two ways

    // way index, one bit for two ways
    typedef logic way_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,  // dirty victim goes out word by word
        FETCH,
        BYPASS,  // non-cacheable single word
        CLEAR_WALK,
        FLUSH_WALK,
        FLUSH_WRITE
    } cache_state_t;

endpackage

`default_nettype wire

// ==== rtl/lru_table.sv ====
// two ways only; N_SETS must be a power of two and at least two, and clear must not meet a touch
`default_nettype none

module lru_table #(
    parameter int N_SETS = 32,
    localparam int SET_BITS = $clog2(N_SETS)
) (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                touch_valid,
    input  logic                lru_clear,
    input  logic [SET_BITS-1:0] touch_set,
    input  logic [SET_BITS-1:0] lookup_set,
    input  cache_pkg::way_t     touch_way,
    output cache_pkg::way_t     lru_way
);

    import cache_pkg::*;

    way_t mru_q [N_SETS];  // most recently used way of each set

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                mru_q[s] <= '0;
            end
        end else if (lru_clear) begin
            for (int s = 0; s < N_SETS; s++) begin
                mru_q[s] <= '0;
            end
        end else if (touch_valid) begin
            mru_q[touch_set] <= touch_way;
        end
    end

    // with two ways the victim is simply the other one
    assign lru_way = way_t'(~mru_q[lookup_set]);

    // the cache only clears the table at the end of a maintenance walk
    a_no_touch_on_clear: assert property (
        @(posedge CLK) disable iff (!nRST) !(touch_valid && lru_clear)
    );

endmodule

`default_nettype wire

// ==== rtl/l1_cache.sv ====
// N_SETS and BLOCK_SIZE must be powers of two and at least two; one memory request at a time
`default_nettype none

module l1_cache #(
    parameter int CACHE_SIZE = 1024,  // bytes
    parameter int BLOCK_SIZE = 4,  // words
    parameter cache_pkg::addr_t NONCACHE_START_ADDR = 32'h8000_0000,
    localparam int N_SETS =
        CACHE_SIZE / (BLOCK_SIZE * cache_pkg::WORD_BYTES * cache_pkg::ASSOC),
    localparam int SET_BITS = $clog2(N_SETS)
) (
    input  logic                CLK,
    input  logic                nRST,
    // processor side
    input  logic                proc_req_valid,
    input  logic                proc_wen,
    input  cache_pkg::addr_t    proc_addr,
    input  cache_pkg::word_t    proc_wdata,
    output logic                proc_req_ready,
    output logic                proc_rvalid,
    output cache_pkg::word_t    proc_rdata,
    // memory side
    output logic                mem_req_valid,
    output logic                mem_wen,
    output cache_pkg::addr_t    mem_addr,
    output cache_pkg::word_t    mem_wdata,
    input  logic                mem_req_ready,
    input  logic                mem_rvalid,
    input  cache_pkg::word_t    mem_rdata,
    // maintenance
    input  logic                clear,
    input  logic                flush,
    output logic                clear_done,
    output logic                flush_done,
    // replacement table
    output logic                touch_valid,
    output logic                lru_clear,
    output logic [SET_BITS-1:0] touch_set,
    output logic [SET_BITS-1:0] lookup_set,
    output cache_pkg::way_t     touch_way,
    input  cache_pkg::way_t     lru_way
);

    import cache_pkg::*;

    localparam int BLOCK_BITS = $clog2(BLOCK_SIZE);
    localparam int TAG_BITS = 32 - SET_BITS - BLOCK_BITS - 2;

    // line state and arrays
    logic [ASSOC-1:0]    valid_q [N_SETS];
    logic [ASSOC-1:0]    dirty_q [N_SETS];
    logic [TAG_BITS-1:0] tag_q   [N_SETS][ASSOC];
    word_t               data_q  [N_SETS][ASSOC][BLOCK_SIZE];

    cache_state_t state;
    logic         up_q;  // first cycle after reset release
    logic         wait_q;  // read issued, data outstanding

    // counters for fills, write-backs and walks
    logic [BLOCK_BITS-1:0] word_q;
    logic [SET_BITS-1:0]   set_q;
    way_t                  way_q;
    way_t                  victim_q;

    // accepted request
    logic  req_wen;
    addr_t req_addr;
    word_t req_wdata;

    logic [TAG_BITS-1:0]   req_tag;
    logic [SET_BITS-1:0]   req_set;
    logic [BLOCK_BITS-1:0] req_off;

    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic                bypass;
    logic                accept;
    logic                mem_xfer;
    logic                lookup_hit;
    logic                fill_beat;
    logic                fill_done;
    logic                bypass_rd_done;
    logic                last_word;
    logic                last_line;
    logic                line_dirty;
    logic                walk_end;
    logic [SET_BITS-1:0] wb_set;
    way_t                wb_way;

    assign req_tag = req_addr[31 -: TAG_BITS];
    assign req_set = req_addr[BLOCK_BITS+2 +: SET_BITS];
    assign req_off = req_addr[2 +: BLOCK_BITS];

    // both tags of the set compared in lookup
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ASSOC; w++) begin
            if (valid_q[req_set][w] && tag_q[req_set][w] == req_tag) begin
                hit = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // an empty way first, else the table's pick
    assign victim_way = !valid_q[req_set][0] ? 1'b0 :
                        !valid_q[req_set][1] ? 1'b1 : lru_way;

    assign bypass = req_addr >= NONCACHE_START_ADDR;
    assign proc_req_ready = up_q && state == IDLE && !clear && !flush;
    assign accept = proc_req_valid && proc_req_ready;
    assign mem_xfer = mem_req_valid && mem_req_ready;
    assign lookup_hit = state == LOOKUP && !bypass && hit;
    assign fill_beat = state == FETCH && wait_q && mem_rvalid;
    assign last_word = word_q == BLOCK_BITS'(BLOCK_SIZE - 1);
    assign fill_done = fill_beat && last_word;
    assign bypass_rd_done = state == BYPASS && wait_q && mem_rvalid;

    assign last_line = set_q == SET_BITS'(N_SETS - 1) && way_q == 1'b1;
    assign line_dirty = valid_q[set_q][way_q] && dirty_q[set_q][way_q];
    assign walk_end = last_line && (state == CLEAR_WALK || (state == FLUSH_WALK && !line_dirty));

    // write-back source, victim line or walked line
    assign wb_set = (state == FLUSH_WRITE) ? set_q : req_set;
    assign wb_way = (state == FLUSH_WRITE) ? way_q : victim_q;

    assign touch_valid = lookup_hit || fill_done;
    assign touch_set = req_set;
    assign touch_way = lookup_hit ? hit_way : victim_q;
    assign lookup_set = req_set;
    assign lru_clear = walk_end;

    // memory request fields
    always_comb begin
        mem_req_valid = 1'b0;
        mem_wen = 1'b0;
        mem_addr = '0;
        mem_wdata = '0;
        case (state)
            WRITE_BACK, FLUSH_WRITE: begin
                mem_req_valid = 1'b1;
                mem_wen = 1'b1;
                mem_addr = {tag_q[wb_set][wb_way], wb_set, word_q, 2'b00};
                mem_wdata = data_q[wb_set][wb_way][word_q];
            end
            FETCH: begin
                mem_req_valid = !wait_q;
                mem_addr = {req_tag, req_set, word_q, 2'b00};
            end
            BYPASS: begin
                mem_req_valid = !wait_q;
                mem_wen = req_wen;
                mem_addr = req_addr;
                mem_wdata = req_wdata;
            end
            default: ;
        endcase
    end

    // controller and line state
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            up_q <= 1'b0;
            wait_q <= 1'b0;
            word_q <= '0;
            set_q <= '0;
            way_q <= '0;
            victim_q <= '0;
            proc_rvalid <= 1'b0;
            clear_done <= 1'b0;
            flush_done <= 1'b0;
            for (int s = 0; s < N_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            up_q <= 1'b1;
            proc_rvalid <= 1'b0;
            clear_done <= 1'b0;
            flush_done <= 1'b0;
            case (state)
                IDLE: begin
                    // done cycle ignored, requester still holds its level
                    if (up_q && flush && !flush_done) begin
                        set_q <= '0;
                        way_q <= '0;
                        state <= FLUSH_WALK;
                    end else if (up_q && clear && !clear_done) begin
                        set_q <= '0;
                        way_q <= '0;
                        state <= CLEAR_WALK;
                    end else if (accept) begin
                        state <= LOOKUP;
                    end
                end
                LOOKUP: begin
                    if (bypass) begin
                        state <= BYPASS;
                    end else if (hit) begin
                        if (req_wen) begin
                            dirty_q[req_set][hit_way] <= 1'b1;
                        end else begin
                            proc_rvalid <= 1'b1;
                        end
                        state <= IDLE;
                    end else begin
                        victim_q <= victim_way;
                        word_q <= '0;
                        if (valid_q[req_set][victim_way] && dirty_q[req_set][victim_way]) begin
                            state <= WRITE_BACK;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                WRITE_BACK: begin
                    if (mem_xfer) begin
                        word_q <= word_q + 1'b1;  // wraps to zero for the fetch
                        if (last_word) begin
                            state <= FETCH;
                        end
                    end
                end
                FETCH: begin
                    if (mem_xfer) begin
                        wait_q <= 1'b1;
                    end
                    if (fill_beat) begin
                        wait_q <= 1'b0;
                        word_q <= word_q + 1'b1;
                        if (last_word) begin
                            valid_q[req_set][victim_q] <= 1'b1;
                            dirty_q[req_set][victim_q] <= req_wen;  // write miss leaves it dirty
                            proc_rvalid <= !req_wen;
                            state <= IDLE;
                        end
                    end
                end
                BYPASS: begin
                    if (mem_xfer) begin
                        if (req_wen) begin
                            state <= IDLE;
                        end else begin
                            wait_q <= 1'b1;
                        end
                    end
                    if (bypass_rd_done) begin
                        wait_q <= 1'b0;
                        proc_rvalid <= 1'b1;
                        state <= IDLE;
                    end
                end
                CLEAR_WALK: begin
                    valid_q[set_q][way_q] <= 1'b0;
                    dirty_q[set_q][way_q] <= 1'b0;  // dirty data dropped
                    way_q <= ~way_q;
                    if (way_q) begin
                        set_q <= set_q + 1'b1;
                    end
                    if (last_line) begin
                        clear_done <= 1'b1;
                        state <= IDLE;
                    end
                end
                FLUSH_WALK: begin
                    if (line_dirty) begin
                        state <= FLUSH_WRITE;
                    end else begin
                        valid_q[set_q][way_q] <= 1'b0;
                        way_q <= ~way_q;
                        if (way_q) begin
                            set_q <= set_q + 1'b1;
                        end
                        if (last_line) begin
                            flush_done <= 1'b1;
                            state <= IDLE;
                        end
                    end
                end
                FLUSH_WRITE: begin
                    if (mem_xfer) begin
                        word_q <= word_q + 1'b1;
                        if (last_word) begin
                            dirty_q[set_q][way_q] <= 1'b0;  // walk revisits and invalidates
                            state <= FLUSH_WALK;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // request, tag and data storage
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_wen <= proc_wen;
            req_addr <= proc_addr;
            req_wdata <= proc_wdata;
        end
        if (lookup_hit) begin
            if (req_wen) begin
                data_q[req_set][hit_way][req_off] <= req_wdata;
            end else begin
                proc_rdata <= data_q[req_set][hit_way][req_off];
            end
        end
        if (fill_beat) begin
            // on a write miss the new word replaces the fetched one
            if (req_wen && word_q == req_off) begin
                data_q[req_set][victim_q][word_q] <= req_wdata;
            end else begin
                data_q[req_set][victim_q][word_q] <= mem_rdata;
            end
            if (last_word) begin
                tag_q[req_set][victim_q] <= req_tag;
                if (word_q == req_off) begin
                    proc_rdata <= mem_rdata;
                end else begin
                    proc_rdata <= data_q[req_set][victim_q][req_off];
                end
            end
        end
        if (bypass_rd_done) begin
            proc_rdata <= mem_rdata;
        end
    end

    // memory request held until taken
    a_mem_stable: assert property (
        @(posedge CLK) disable iff (!nRST)
        mem_req_valid && !mem_req_ready |=>
            mem_req_valid && $stable(mem_wen) && $stable(mem_addr) && $stable(mem_wdata)
    );

    // read data only in the cycle right after leaving a busy state
    a_rvalid_not_idle: assert property (
        @(posedge CLK) disable iff (!nRST)
        state == IDLE && $past(state) == IDLE |-> !proc_rvalid
    );

    a_no_mem_in_idle: assert property (
        @(posedge CLK) disable iff (!nRST)
        state inside {IDLE, LOOKUP} |-> !mem_req_valid
    );

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
// CACHE_SIZE in bytes and BLOCK_SIZE in words must give at least two sets; all accesses are words
`default_nettype none

module cache_top #(
    parameter int CACHE_SIZE = 1024,
    parameter int BLOCK_SIZE = 4,
    parameter cache_pkg::addr_t NONCACHE_START_ADDR = 32'h8000_0000
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             proc_req_valid,
    input  logic             proc_wen,
    input  cache_pkg::addr_t proc_addr,
    input  cache_pkg::word_t proc_wdata,
    output logic             proc_req_ready,
    output logic             proc_rvalid,
    output cache_pkg::word_t proc_rdata,
    output logic             mem_req_valid,
    output logic             mem_wen,
    output cache_pkg::addr_t mem_addr,
    output cache_pkg::word_t mem_wdata,
    input  logic             mem_req_ready,
    input  logic             mem_rvalid,
    input  cache_pkg::word_t mem_rdata,
    input  logic             clear,
    input  logic             flush,
    output logic             clear_done,
    output logic             flush_done
);

    import cache_pkg::*;

    localparam int N_SETS = CACHE_SIZE / (BLOCK_SIZE * WORD_BYTES * ASSOC);
    localparam int SET_BITS = $clog2(N_SETS);

    // replacement table links
    logic                touch_valid;
    logic                lru_clear;
    logic [SET_BITS-1:0] touch_set;
    logic [SET_BITS-1:0] lookup_set;
    way_t                touch_way;
    way_t                lru_way;

    l1_cache #(
        .CACHE_SIZE         (CACHE_SIZE),
        .BLOCK_SIZE         (BLOCK_SIZE),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) l1_cache_i (
        .CLK, .nRST,
        .proc_req_valid, .proc_wen, .proc_addr, .proc_wdata,
        .proc_req_ready, .proc_rvalid, .proc_rdata,
        .mem_req_valid, .mem_wen, .mem_addr, .mem_wdata,
        .mem_req_ready, .mem_rvalid, .mem_rdata,
        .clear, .flush, .clear_done, .flush_done,
        .touch_valid, .lru_clear, .touch_set, .lookup_set, .touch_way, .lru_way
    );

    lru_table #(
        .N_SETS(N_SETS)
    ) lru_table_i (
        .CLK, .nRST,
        .touch_valid, .lru_clear, .touch_set, .lookup_set, .touch_way, .lru_way
    );

endmodule

`default_nettype wire

// ==== bench/mem_bfm.sv ====
// word memory of 2**ADDR_BITS words, upper address bits alias; reset refills every word from its address
`default_nettype none

module mem_bfm #(
    parameter int ADDR_BITS = 10,
    parameter int SEED = 32'h3a78
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             mem_req_valid,
    input  logic             mem_wen,
    input  cache_pkg::addr_t mem_addr,
    input  cache_pkg::word_t mem_wdata,
    output logic             mem_req_ready,
    output logic             mem_rvalid,
    output cache_pkg::word_t mem_rdata,
    // direct write from the bench
    input  logic             poke_valid,
    input  cache_pkg::addr_t poke_addr,
    input  cache_pkg::word_t poke_wdata
);

    import cache_pkg::*;

    localparam int DEPTH = 2 ** ADDR_BITS;

    word_t      mem [DEPTH];
    int         seed = SEED;
    logic [1:0] delay_q;  // cycles left before ready

    function automatic logic [ADDR_BITS-1:0] word_index(input addr_t addr);
        return addr[ADDR_BITS+1:2];
    endfunction

    // every word differs, pattern spread over the whole index
    function automatic word_t fill_word(input int idx);
        return 32'(idx) * 32'h9e37_79b9 + 32'h3c6e_f372;
    endfunction

    assign mem_req_ready = mem_req_valid && delay_q == 2'd0;

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            delay_q <= 2'($random(seed));
            mem_rvalid <= 1'b0;
            mem_rdata <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                mem[ADDR_BITS'(i)] <= fill_word(i);
            end
        end else begin
            mem_rvalid <= 1'b0;
            if (mem_req_valid && delay_q != 2'd0) begin
                delay_q <= delay_q - 2'd1;
            end
            if (mem_req_ready) begin
                delay_q <= 2'($random(seed));  // latency of the next request
                if (mem_wen) begin
                    mem[word_index(mem_addr)] <= mem_wdata;
                end else begin
                    mem_rvalid <= 1'b1;  // data the cycle after the transfer
                    mem_rdata <= mem[word_index(mem_addr)];
                end
            end
            if (poke_valid) begin
                mem[word_index(poke_addr)] <= poke_wdata;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_cache_top.sv ====
// 256-byte cache with 4-word blocks (8 sets); bench memory aliases above 4 KB, so tests stay below
`default_nettype none

module tb_cache_top;

    import cache_pkg::*;

    localparam int CACHE_SIZE = 256;
    localparam int BLOCK_SIZE = 4;
    localparam addr_t NONCACHE_START_ADDR = 32'h8000_0000;
    localparam int MEM_BITS = 10;
    localparam int MEM_WORDS = 2 ** MEM_BITS;
    localparam int RESET_CYCLES = 16;
    localparam int N_TESTS = 6;
    localparam int TEST_CYCLES = 3000;  // generous, flush walks every line
    localparam addr_t SET_STRIDE = 32'h80;  // 8 sets of 16 bytes

    logic  CLK;
    logic  nRST;
    logic  proc_req_valid;
    logic  proc_wen;
    addr_t proc_addr;
    word_t proc_wdata;
    logic  proc_req_ready;
    logic  proc_rvalid;
    word_t proc_rdata;
    logic  mem_req_valid;
    logic  mem_wen;
    addr_t mem_addr;
    word_t mem_wdata;
    logic  mem_req_ready;
    logic  mem_rvalid;
    word_t mem_rdata;
    logic  clear;
    logic  flush;
    logic  clear_done;
    logic  flush_done;
    logic  poke_valid;
    addr_t poke_addr;
    word_t poke_wdata;

    word_t shadow [MEM_WORDS];  // value the processor should see

    cache_top #(
        .CACHE_SIZE         (CACHE_SIZE),
        .BLOCK_SIZE         (BLOCK_SIZE),
        .NONCACHE_START_ADDR(NONCACHE_START_ADDR)
    ) cache_top_i (
        .CLK, .nRST,
        .proc_req_valid, .proc_wen, .proc_addr, .proc_wdata,
        .proc_req_ready, .proc_rvalid, .proc_rdata,
        .mem_req_valid, .mem_wen, .mem_addr, .mem_wdata,
        .mem_req_ready, .mem_rvalid, .mem_rdata,
        .clear, .flush, .clear_done, .flush_done
    );

    mem_bfm #(
        .ADDR_BITS(MEM_BITS),
        .SEED     (32'h3a78)
    ) mem_bfm_i (
        .CLK, .nRST,
        .mem_req_valid, .mem_wen, .mem_addr, .mem_wdata,
        .mem_req_ready, .mem_rvalid, .mem_rdata,
        .poke_valid, .poke_addr, .poke_wdata
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // whole run limited by the test budget
    initial begin
        repeat (RESET_CYCLES + N_TESTS * TEST_CYCLES) @(posedge CLK);
        $display("timeout: the tests did not finish in %0d cycles", N_TESTS * TEST_CYCLES);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [MEM_BITS-1:0] word_index(input addr_t addr);
        return addr[MEM_BITS+1:2];
    endfunction

    task automatic check_value(input string test, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", test, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // lat counts falling edges from the transfer until ready is back
    task automatic write_word(input addr_t addr, input word_t data, output int lat);
        @(negedge CLK);
        proc_req_valid = 1'b1;
        proc_wen = 1'b1;
        proc_addr = addr;
        proc_wdata = data;
        while (!proc_req_ready) @(negedge CLK);
        @(negedge CLK);  // transfer done on the edge before
        proc_req_valid = 1'b0;
        lat = 1;
        while (!proc_req_ready) begin
            @(negedge CLK);
            lat++;
        end
    endtask

    task automatic read_word(input addr_t addr, output word_t data, output int lat);
        @(negedge CLK);
        proc_req_valid = 1'b1;
        proc_wen = 1'b0;
        proc_addr = addr;
        while (!proc_req_ready) @(negedge CLK);
        @(negedge CLK);
        proc_req_valid = 1'b0;
        lat = 1;
        while (!proc_rvalid) begin
            @(negedge CLK);
            lat++;
        end
        data = proc_rdata;
    endtask

    task automatic poke_memory(input addr_t addr, input word_t data);
        @(negedge CLK);
        poke_valid = 1'b1;
        poke_addr = addr;
        poke_wdata = data;
        @(negedge CLK);
        poke_valid = 1'b0;
    endtask

    // request held until its done pulse
    task automatic run_maintenance(input logic do_flush);
        @(negedge CLK);
        flush = do_flush;
        clear = !do_flush;
        while (!(do_flush ? flush_done : clear_done)) @(negedge CLK);
        flush = 1'b0;
        clear = 1'b0;
    endtask

    task automatic read_miss_then_hit();
        addr_t addr = 32'h040;
        word_t got;
        int    lat;
        read_word(addr, got, lat);
        check_value("read_miss_then_hit", shadow[word_index(addr)], got);
        read_word(addr, got, lat);
        check_value("read_miss_then_hit", shadow[word_index(addr)], got);
        check_value("read_miss_then_hit latency", 32'd2, 32'(lat));
    endtask

    task automatic write_hit_readback();
        addr_t addr = 32'h044;  // same line as the previous test
        word_t old = shadow[word_index(addr)];
        word_t got;
        int    lat;
        write_word(addr, 32'hc0de_0001, lat);
        check_value("write_hit_readback latency", 32'd2, 32'(lat));
        shadow[word_index(addr)] = 32'hc0de_0001;
        read_word(addr, got, lat);
        check_value("write_hit_readback", shadow[word_index(addr)], got);
        check_value("write_hit_readback memory", old, mem_bfm_i.mem[word_index(addr)]);
    endtask

    task automatic evict_dirty_line();
        addr_t addrs [3] = '{32'h000, SET_STRIDE, 2 * SET_STRIDE};
        word_t got;
        int    lat;
        write_word(addrs[0], 32'hd1d1_0000, lat);
        shadow[word_index(addrs[0])] = 32'hd1d1_0000;
        read_word(addrs[1], got, lat);
        read_word(addrs[2], got, lat);  // first line is LRU, written back
        check_value("evict_dirty_line memory", shadow[word_index(addrs[0])],
                    mem_bfm_i.mem[word_index(addrs[0])]);
        foreach (addrs[i]) begin
            read_word(addrs[i], got, lat);
            check_value("evict_dirty_line", shadow[word_index(addrs[i])], got);
        end
    endtask

    task automatic noncache_bypass();
        addr_t addr = NONCACHE_START_ADDR + 32'hf00;
        word_t got;
        int    lat;
        write_word(addr, 32'hb7a5_5001, lat);
        shadow[word_index(addr)] = 32'hb7a5_5001;
        check_value("noncache_bypass memory", 32'hb7a5_5001, mem_bfm_i.mem[word_index(addr)]);
        poke_memory(addr, 32'hb7a5_5002);
        shadow[word_index(addr)] = 32'hb7a5_5002;
        read_word(addr, got, lat);
        check_value("noncache_bypass", shadow[word_index(addr)], got);
    endtask

    task automatic flush_all();
        addr_t addrs [4] = '{32'h210, 32'h224, 32'h3b8, 32'h200};
        word_t got;
        int    lat;
        foreach (addrs[i]) begin
            write_word(addrs[i], 32'hf1a5_0000 + 32'(i), lat);
            shadow[word_index(addrs[i])] = 32'hf1a5_0000 + 32'(i);
        end
        run_maintenance(1'b1);
        // every dirty line so far must be back in memory
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_value("flush_all memory", shadow[MEM_BITS'(i)], mem_bfm_i.mem[MEM_BITS'(i)]);
        end
        foreach (addrs[i]) begin
            read_word(addrs[i], got, lat);
            check_value("flush_all", shadow[word_index(addrs[i])], got);
            check_value("flush_all miss", 32'd1, 32'(lat > 2));  // slower than a hit
        end
    endtask

    task automatic clear_all();
        addr_t addrs [2] = '{32'h050, 32'h1e8};
        word_t old [2];
        word_t got;
        int    lat;
        foreach (addrs[i]) begin
            old[i] = shadow[word_index(addrs[i])];
            write_word(addrs[i], 32'hc1ea_0000 + 32'(i), lat);
            shadow[word_index(addrs[i])] = 32'hc1ea_0000 + 32'(i);
            read_word(addrs[i], got, lat);
            check_value("clear_all write", shadow[word_index(addrs[i])], got);
        end
        run_maintenance(1'b0);
        foreach (addrs[i]) begin
            shadow[word_index(addrs[i])] = old[i];  // dirty words discarded
            read_word(addrs[i], got, lat);
            check_value("clear_all", shadow[word_index(addrs[i])], got);
        end
    endtask

    initial begin
        nRST = 1'b0;
        proc_req_valid = 1'b0;
        proc_wen = 1'b0;
        proc_addr = '0;
        proc_wdata = '0;
        clear = 1'b0;
        flush = 1'b0;
        poke_valid = 1'b0;
        poke_addr = '0;
        poke_wdata = '0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[MEM_BITS'(i)] = mem_bfm_i.mem[MEM_BITS'(i)];
        end
        read_miss_then_hit();
        write_hit_readback();
        evict_dirty_line();
        noncache_bypass();
        flush_all();
        clear_all();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/cache_pkg.sv
rtl/lru_table.sv
rtl/l1_cache.sv
rtl/cache_top.sv
bench/mem_bfm.sv
bench/tb_cache_top.sv

// ==== Makefile ====
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP       ?= tb_cache_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test: $(SIM)
	./$(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
